/* bench/tb_cluster_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cluster_mem;
	import cluster_mem_pkg::*;

	localparam int    CORES = 2;
	localparam word_t BASE = 32'h0001_0000;
	localparam word_t OFFS = 32'h0001_0000;
	localparam word_t LEN = 32'd16;
	localparam int    COPY_WORDS = LEN / 4;
	localparam int    CLK_PERIOD = 10;
	localparam int    TEST_COUNT = 10;
	localparam int    TEST_CYCLES = 150;
	localparam int    WAIT_LIMIT = 100;

	logic             clk;
	logic             resetn;
	logic [CORES-1:0] core_mem_valid;
	logic [CORES-1:0] core_mem_instr;
	word_t            core_mem_addr [CORES-1:0];
	word_t            core_mem_wdata [CORES-1:0];
	strb_t            core_mem_wstrb [CORES-1:0];
	logic [CORES-1:0] core_mem_ready;
	word_t            core_mem_rdata [CORES-1:0];
	logic             mem_valid;
	logic             mem_instr;
	word_t            mem_addr;
	word_t            mem_wdata;
	strb_t            mem_wstrb;
	logic             mem_ready;
	word_t            mem_rdata;
	logic [CORES-1:0] copy_req;
	logic [CORES-1:0] copy_done;
	logic             copy_mem_valid;
	word_t            copy_mem_addr;
	word_t            copy_mem_wdata;
	strb_t            copy_mem_wstrb;
	logic             copy_mem_ready;
	word_t            copy_mem_rdata;

	word_t exp_addr [CORES-1:0];
	word_t exp_rdata [CORES-1:0];
	int    copy_writes;
	int    errors;
	int    tests;

	cluster_mem #(
		.CORES_COUNT     (CORES),
		.PRIVATE_MEM_BASE(BASE),
		.PRIVATE_MEM_OFFS(OFFS),
		.PRIVATE_MEM_LEN (LEN)
	) dut (
		.clk           (clk),
		.resetn        (resetn),
		.core_mem_valid(core_mem_valid),
		.core_mem_instr(core_mem_instr),
		.core_mem_addr (core_mem_addr),
		.core_mem_wdata(core_mem_wdata),
		.core_mem_wstrb(core_mem_wstrb),
		.core_mem_ready(core_mem_ready),
		.core_mem_rdata(core_mem_rdata),
		.mem_valid     (mem_valid),
		.mem_instr     (mem_instr),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_wstrb     (mem_wstrb),
		.mem_ready     (mem_ready),
		.mem_rdata     (mem_rdata),
		.copy_req      (copy_req),
		.copy_done     (copy_done),
		.copy_mem_valid(copy_mem_valid),
		.copy_mem_addr (copy_mem_addr),
		.copy_mem_wdata(copy_mem_wdata),
		.copy_mem_wstrb(copy_mem_wstrb),
		.copy_mem_ready(copy_mem_ready),
		.copy_mem_rdata(copy_mem_rdata)
	);

	tb_mem_model mem_main (
		.clk   (clk),
		.resetn(resetn),
		.valid (mem_valid),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.wstrb (mem_wstrb),
		.ready (mem_ready),
		.rdata (mem_rdata)
	);

	tb_mem_model mem_copy (
		.clk   (clk),
		.resetn(resetn),
		.valid (copy_mem_valid),
		.addr  (copy_mem_addr),
		.wdata (copy_mem_wdata),
		.wstrb (copy_mem_wstrb),
		.ready (copy_mem_ready),
		.rdata (copy_mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", TEST_COUNT * TEST_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// Writes seen on the copy port
	always @(posedge clk) begin
		if (!resetn)
			copy_writes <= 0;
		else if (copy_mem_valid && copy_mem_ready && copy_mem_wstrb != '0)
			copy_writes <= copy_writes + 1;
	end

	a_reset_low: assert property (@(posedge clk) !resetn |=> (core_mem_ready == '0
		&& !mem_valid && !copy_mem_valid && copy_done == '0
		&& mem_wstrb == '0 && copy_mem_wstrb == '0))
	else begin
		errors++;
		$display("Error at %0t: outputs not low after reset", $time);
	end

	a_main_addr: assert property (@(posedge clk) disable iff (!resetn) mem_valid |->
		(core_mem_valid[0] && mem_addr == exp_addr[0]
			&& mem_instr == core_mem_instr[0] && mem_wstrb == core_mem_wstrb[0])
		|| (core_mem_valid[1] && mem_addr == exp_addr[1]
			&& mem_instr == core_mem_instr[1] && mem_wstrb == core_mem_wstrb[1]))
	else begin
		errors++;
		$display("Error at %0t: main port request %h/%b/%h matches no core request", $time,
			$sampled(mem_addr), $sampled(mem_instr), $sampled(mem_wstrb));
	end

	for (genvar i = 0; i < CORES; i++) begin : g_core_chk
		a_rdata: assert property (@(posedge clk) disable iff (!resetn)
			core_mem_ready[i] && core_mem_wstrb[i] == '0 |-> core_mem_rdata[i] == exp_rdata[i])
		else begin
			errors++;
			$display("Error at %0t: core %0d read %h, expected %h", $time, i,
				$sampled(core_mem_rdata[i]), exp_rdata[i]);
		end
	end

	a_copy_done: assert property (@(posedge clk) disable iff (!resetn)
		$rose(copy_done[0]) |-> copy_writes == COPY_WORDS)
	else begin
		errors++;
		$display("Error at %0t: copy_done rose after %0d of %0d words", $time,
			$sampled(copy_writes), COPY_WORDS);
	end

	a_done_fall: assert property (@(posedge clk) disable iff (!resetn)
		$fell(copy_done[0]) |-> !$past(copy_req[0]))
	else begin
		errors++;
		$display("Error at %0t: copy_done fell while copy_req was high", $time);
	end

	task automatic issue(input int c, input logic instr, input word_t addr, input word_t wdata,
		input strb_t wstrb, input word_t expect_addr, input word_t expect_rdata);
		exp_addr[c] = expect_addr;
		exp_rdata[c] = expect_rdata;
		core_mem_instr[c] = instr;
		core_mem_addr[c] = addr;
		core_mem_wdata[c] = wdata;
		core_mem_wstrb[c] = wstrb;
		core_mem_valid[c] = 1'b1;
		tests++;
	endtask

	// Waits for the ready pulse of core c, then releases its request
	task automatic finish_access(input int c);
		int n;
		n = 0;
		while (!core_mem_ready[c] && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!core_mem_ready[c]) begin
			errors++;
			$display("Core %0d got no ready pulse within %0d cycles", c, WAIT_LIMIT);
		end
		core_mem_valid[c] = 1'b0;
	endtask

	task automatic read_public(input int c, input word_t addr);
		@(posedge clk);
		#1;
		issue(c, 1'b0, addr, 32'h0, 4'b0000, addr, mem_main.peek(addr));
		finish_access(c);
	endtask

	task automatic write_then_read(input int c, input word_t offs, input word_t data);
		word_t core_addr;
		word_t target;
		core_addr = {8'hff, offs[23:0]};
		target = BASE + OFFS * word_t'(c) + offs;
		@(posedge clk);
		#1;
		issue(c, 1'b0, core_addr, data, 4'b1111, target, 32'h0);
		finish_access(c);
		stored: assert (mem_main.peek(target) == data)
		else begin
			errors++;
			$display("Error at %0t: %h holds %h, expected %h", $time, target,
				mem_main.peek(target), data);
		end
		@(posedge clk);
		#1;
		issue(c, 1'b0, core_addr, 32'h0, 4'b0000, target, data);
		finish_access(c);
	endtask

	task automatic order_check(input logic fetch1, input int first, input word_t addr);
		int n;
		@(posedge clk);
		#1;
		issue(0, 1'b0, addr, 32'h0, 4'b0000, addr, mem_main.peek(addr));
		issue(1, fetch1, addr + 4, 32'h0, 4'b0000, addr + 4, mem_main.peek(addr + 4));
		n = 0;
		while (core_mem_ready == '0 && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		served_first: assert (core_mem_ready[first] && !core_mem_ready[1 - first])
		else begin
			errors++;
			$display("Error at %0t: ready %b, core %0d should be served first", $time,
				core_mem_ready, first);
		end
		finish_access(first);
		finish_access(1 - first);
	endtask

	task automatic copy_check;
		word_t snap [COPY_WORDS];
		word_t src;
		word_t dst;
		int    n;
		src = BASE;
		dst = BASE + OFFS;
		for (int k = 0; k < COPY_WORDS; k++)
			snap[k] = mem_copy.peek(src + 4 * k);
		@(posedge clk);
		#1;
		tests++;
		copy_req[0] = 1'b1;
		n = 0;
		while (!copy_done[0] && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!copy_done[0]) begin
			errors++;
			$display("copy_done did not rise within %0d cycles", WAIT_LIMIT);
		end
		for (int k = 0; k < COPY_WORDS; k++) begin
			copied: assert (mem_copy.peek(dst + 4 * k) == snap[k])
			else begin
				errors++;
				$display("Error at %0t: word %0d of window 1 is %h, expected %h", $time, k,
					mem_copy.peek(dst + 4 * k), snap[k]);
			end
		end
		copy_req[0] = 1'b0;
		n = 0;
		while (copy_done[0] && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (copy_done[0]) begin
			errors++;
			$display("copy_done stayed high after copy_req dropped");
		end
	endtask

	initial begin
		errors = 0;
		tests = 0;
		resetn = 1'b0;
		core_mem_valid = '0;
		core_mem_instr = '0;
		copy_req = '0;
		for (int c = 0; c < CORES; c++) begin
			core_mem_addr[c] = '0;
			core_mem_wdata[c] = '0;
			core_mem_wstrb[c] = '0;
			exp_addr[c] = '0;
			exp_rdata[c] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		tests++;

		read_public(0, 32'h0000_0100);
		read_public(1, 32'h0000_0204);
		write_then_read(0, 32'h0000_0040, 32'h1234_5678);
		write_then_read(1, 32'h0000_0040, 32'hcafe_0001);
		// Data reads on both cores, then a fetch on core 1 only
		order_check(1'b0, 0, 32'h0000_0300);
		order_check(1'b1, 1, 32'h0000_0310);
		copy_check();

		repeat (2) @(posedge clk);
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
	parameter logic [15:0] SEED = 16'd52096
) (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire                            valid,
	input  wire  cluster_mem_pkg::word_t   addr,
	input  wire  cluster_mem_pkg::word_t   wdata,
	input  wire  cluster_mem_pkg::strb_t   wstrb,
	output logic                           ready,
	output cluster_mem_pkg::word_t         rdata
);
	import cluster_mem_pkg::*;

	word_t       mem [0:65535];
	logic [15:0] lfsr;

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic word_t peek(input word_t a);
		return mem[a[17:2]];
	endfunction

	// Each cell starts as its inverted index and its index
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = {~i[15:0], i[15:0]};
	end

	initial begin
		int delay;
		lfsr = SEED;
		ready = 1'b0;
		rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			if (resetn && valid) begin
				// Two LFSR bits give 0 to 3 wait cycles
				delay = 0;
				for (int b = 0; b < 2; b++) begin
					delay = (delay << 1) | int'(lfsr[0]);
					lfsr = galois_step(lfsr);
				end
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				rdata = mem[addr[17:2]];
				for (int k = 0; k < 4; k++) begin
					if (wstrb[k])
						mem[addr[17:2]][8*k +: 8] = wdata[8*k +: 8];
				end
				ready = 1'b1;
				@(posedge clk);
				#1;
				ready = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/cluster_mem_pkg.sv
hdl/addr_translator.sv
hdl/mem_arbiter.sv
hdl/copy_scheduler.sv
hdl/mem_mover.sv
hdl/cluster_mem.sv
bench/tb_mem_model.sv
bench/tb_cluster_mem.sv

/* hdl/addr_translator.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_translator #(
	parameter cluster_mem_pkg::word_t WINDOW_BASE = 32'h0001_0000
) (
	input  wire                            clk,
	input  wire                            resetn,

	input  wire                            core_mem_valid,
	input  wire                            core_mem_instr,
	input  wire  cluster_mem_pkg::word_t   core_mem_addr,
	input  wire  cluster_mem_pkg::word_t   core_mem_wdata,
	input  wire  cluster_mem_pkg::strb_t   core_mem_wstrb,
	output logic                           core_mem_ready,
	output cluster_mem_pkg::word_t         core_mem_rdata,

	output logic                           arb_valid,
	output logic                           arb_instr,
	output cluster_mem_pkg::word_t         arb_addr,
	output cluster_mem_pkg::word_t         arb_wdata,
	output cluster_mem_pkg::strb_t         arb_wstrb,
	input  wire                            arb_ready,
	input  wire  cluster_mem_pkg::word_t   arb_rdata
);
	import cluster_mem_pkg::*;

	addr_u in_addr;
	word_t mapped_addr;
	logic  take;

	assign in_addr.raw = core_mem_addr;

	always_comb begin
		if (in_addr.win.tag == PRIVATE_TAG)
			mapped_addr = WINDOW_BASE + word_t'(in_addr.win.offset);
		else
			mapped_addr = in_addr.raw;
	end

	// Core still holds valid in the cycle it sees ready
	assign take = core_mem_valid && !arb_valid && !core_mem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			arb_valid <= 1'b0;
			core_mem_ready <= 1'b0;
		end else begin
			core_mem_ready <= 1'b0;
			if (arb_valid && arb_ready) begin
				arb_valid <= 1'b0;
				core_mem_ready <= 1'b1;
			end else if (take) begin
				arb_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			arb_instr <= core_mem_instr;
			arb_addr <= mapped_addr;
			arb_wdata <= core_mem_wdata;
			arb_wstrb <= core_mem_wstrb;
		end
		if (arb_valid && arb_ready)
			core_mem_rdata <= arb_rdata;
	end

endmodule

`default_nettype wire

/* hdl/cluster_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module cluster_mem #(
	parameter int                     CORES_COUNT = 2,
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_BASE = 32'h0001_0000,
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_OFFS = 32'h0001_0000,
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_LEN = 32'h0000_0100
) (
	input  wire                           clk,
	input  wire                           resetn,

	input  wire [CORES_COUNT-1:0]         core_mem_valid,
	input  wire [CORES_COUNT-1:0]         core_mem_instr,
	input  wire cluster_mem_pkg::word_t   core_mem_addr [CORES_COUNT-1:0],
	input  wire cluster_mem_pkg::word_t   core_mem_wdata [CORES_COUNT-1:0],
	input  wire cluster_mem_pkg::strb_t   core_mem_wstrb [CORES_COUNT-1:0],
	output wire [CORES_COUNT-1:0]         core_mem_ready,
	output wire cluster_mem_pkg::word_t   core_mem_rdata [CORES_COUNT-1:0],

	output wire                           mem_valid,
	output wire                           mem_instr,
	output wire cluster_mem_pkg::word_t   mem_addr,
	output wire cluster_mem_pkg::word_t   mem_wdata,
	output wire cluster_mem_pkg::strb_t   mem_wstrb,
	input  wire                           mem_ready,
	input  wire cluster_mem_pkg::word_t   mem_rdata,

	input  wire [CORES_COUNT-1:0]         copy_req,
	output wire [CORES_COUNT-1:0]         copy_done,

	output wire                           copy_mem_valid,
	output wire cluster_mem_pkg::word_t   copy_mem_addr,
	output wire cluster_mem_pkg::word_t   copy_mem_wdata,
	output wire cluster_mem_pkg::strb_t   copy_mem_wstrb,
	input  wire                           copy_mem_ready,
	input  wire cluster_mem_pkg::word_t   copy_mem_rdata
);
	import cluster_mem_pkg::*;

	// Translated requests into the arbiter
	wire [CORES_COUNT-1:0] arb_valid;
	wire [CORES_COUNT-1:0] arb_instr;
	wire [CORES_COUNT-1:0] arb_ready;
	wire word_t            arb_addr [CORES_COUNT-1:0];
	wire word_t            arb_wdata [CORES_COUNT-1:0];
	wire strb_t            arb_wstrb [CORES_COUNT-1:0];
	wire word_t            arb_rdata [CORES_COUNT-1:0];

	wire        mover_start;
	wire        mover_busy;
	wire        mover_done;
	wire word_t mover_src;
	wire word_t mover_dst;

	for (genvar i = 0; i < CORES_COUNT; i++) begin : g_core
		addr_translator #(
			.WINDOW_BASE(PRIVATE_MEM_BASE + PRIVATE_MEM_OFFS * word_t'(i))
		) u_translator (
			.clk           (clk),
			.resetn        (resetn),
			.core_mem_valid(core_mem_valid[i]),
			.core_mem_instr(core_mem_instr[i]),
			.core_mem_addr (core_mem_addr[i]),
			.core_mem_wdata(core_mem_wdata[i]),
			.core_mem_wstrb(core_mem_wstrb[i]),
			.core_mem_ready(core_mem_ready[i]),
			.core_mem_rdata(core_mem_rdata[i]),
			.arb_valid     (arb_valid[i]),
			.arb_instr     (arb_instr[i]),
			.arb_addr      (arb_addr[i]),
			.arb_wdata     (arb_wdata[i]),
			.arb_wstrb     (arb_wstrb[i]),
			.arb_ready     (arb_ready[i]),
			.arb_rdata     (arb_rdata[i])
		);
	end

	mem_arbiter #(
		.CORES_COUNT(CORES_COUNT)
	) u_arbiter (
		.clk       (clk),
		.resetn    (resetn),
		.core_valid(arb_valid),
		.core_instr(arb_instr),
		.core_addr (arb_addr),
		.core_wdata(arb_wdata),
		.core_wstrb(arb_wstrb),
		.core_ready(arb_ready),
		.core_rdata(arb_rdata),
		.mem_valid (mem_valid),
		.mem_instr (mem_instr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	copy_scheduler #(
		.CORES_COUNT     (CORES_COUNT),
		.PRIVATE_MEM_BASE(PRIVATE_MEM_BASE),
		.PRIVATE_MEM_OFFS(PRIVATE_MEM_OFFS)
	) u_scheduler (
		.clk        (clk),
		.resetn     (resetn),
		.copy_req   (copy_req),
		.copy_done  (copy_done),
		.mover_start(mover_start),
		.mover_src  (mover_src),
		.mover_dst  (mover_dst),
		.mover_busy (mover_busy),
		.mover_done (mover_done)
	);

	mem_mover #(
		.PRIVATE_MEM_LEN(PRIVATE_MEM_LEN)
	) u_mover (
		.clk           (clk),
		.resetn        (resetn),
		.start         (mover_start),
		.src           (mover_src),
		.dst           (mover_dst),
		.busy          (mover_busy),
		.done          (mover_done),
		.copy_mem_valid(copy_mem_valid),
		.copy_mem_addr (copy_mem_addr),
		.copy_mem_wdata(copy_mem_wdata),
		.copy_mem_wstrb(copy_mem_wstrb),
		.copy_mem_ready(copy_mem_ready),
		.copy_mem_rdata(copy_mem_rdata)
	);

endmodule

`default_nettype wire

/* hdl/cluster_mem_pkg.sv */
`default_nettype none

package cluster_mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;

	// Core address seen as a raw word or as window tag and offset
	typedef union packed {
		word_t raw;
		struct packed {
			logic [7:0]  tag;
			logic [23:0] offset;
		} win;
	} addr_u;

	// Top byte all ones selects the private window
	localparam logic [7:0] PRIVATE_TAG = 8'hff;

	localparam int WORD_BYTES = 4;

	localparam strb_t STRB_FULL = 4'b1111;

endpackage

`default_nettype wire

/* hdl/copy_scheduler.sv */
`timescale 1ns/1ns
`default_nettype none

module copy_scheduler #(
	parameter int                     CORES_COUNT = 2,
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_BASE = 32'h0001_0000,
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_OFFS = 32'h0001_0000
) (
	input  wire                      clk,
	input  wire                      resetn,

	input  wire  [CORES_COUNT-1:0]   copy_req,
	output logic [CORES_COUNT-1:0]   copy_done,

	output logic                     mover_start,
	output cluster_mem_pkg::word_t   mover_src,
	output cluster_mem_pkg::word_t   mover_dst,
	input  wire                      mover_busy,
	input  wire                      mover_done
);
	import cluster_mem_pkg::*;

	localparam int IDX_W = (CORES_COUNT > 1) ? $clog2(CORES_COUNT) : 1;

	logic [CORES_COUNT-1:0] req_q;
	logic [CORES_COUNT-1:0] pending;
	logic [IDX_W-1:0]       pick;
	logic [IDX_W-1:0]       sel;
	logic                   launch;
	word_t                  win_src [CORES_COUNT-1:0];
	word_t                  win_dst [CORES_COUNT-1:0];

	// Mover busy only rises the cycle after start
	assign launch = |pending && !mover_busy && !mover_start;

	always_comb begin
		pick = '0;
		for (int i = CORES_COUNT - 1; i >= 0; i--) begin
			win_src[i] = PRIVATE_MEM_BASE + PRIVATE_MEM_OFFS * word_t'(i);
			// Last core copies onto its own window
			if (i < CORES_COUNT - 1)
				win_dst[i] = PRIVATE_MEM_BASE + PRIVATE_MEM_OFFS * word_t'(i + 1);
			else
				win_dst[i] = win_src[i];
			if (pending[i])
				pick = IDX_W'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_q <= '0;
			pending <= '0;
			copy_done <= '0;
			mover_start <= 1'b0;
			sel <= '0;
		end else begin
			req_q <= copy_req;
			mover_start <= launch;
			if (launch)
				sel <= pick;
			for (int i = 0; i < CORES_COUNT; i++) begin
				if (copy_req[i] && !req_q[i])
					pending[i] <= 1'b1;
				else if (launch && pick == IDX_W'(i))
					pending[i] <= 1'b0;

				if (mover_done && sel == IDX_W'(i))
					copy_done[i] <= 1'b1;
				else if (!copy_req[i])
					copy_done[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			mover_src <= win_src[pick];
			mover_dst <= win_dst[pick];
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
	parameter int CORES_COUNT = 2
) (
	input  wire                            clk,
	input  wire                            resetn,

	input  wire  [CORES_COUNT-1:0]         core_valid,
	input  wire  [CORES_COUNT-1:0]         core_instr,
	input  wire  cluster_mem_pkg::word_t   core_addr [CORES_COUNT-1:0],
	input  wire  cluster_mem_pkg::word_t   core_wdata [CORES_COUNT-1:0],
	input  wire  cluster_mem_pkg::strb_t   core_wstrb [CORES_COUNT-1:0],
	output logic [CORES_COUNT-1:0]         core_ready,
	output cluster_mem_pkg::word_t         core_rdata [CORES_COUNT-1:0],

	output logic                           mem_valid,
	output logic                           mem_instr,
	output cluster_mem_pkg::word_t         mem_addr,
	output cluster_mem_pkg::word_t         mem_wdata,
	output cluster_mem_pkg::strb_t         mem_wstrb,
	input  wire                            mem_ready,
	input  wire  cluster_mem_pkg::word_t   mem_rdata
);
	import cluster_mem_pkg::*;

	localparam int IDX_W = (CORES_COUNT > 1) ? $clog2(CORES_COUNT) : 1;

	logic [CORES_COUNT-1:0] valid_q;
	logic [CORES_COUNT-1:0] pending;
	logic                   instr_any;
	logic [IDX_W-1:0]       pick;
	logic [IDX_W-1:0]       sel;
	logic                   claimed;
	logic                   served;

	assign instr_any = |(pending & core_instr);
	assign served = mem_valid && mem_ready;

	// Fetches first, then lowest index
	always_comb begin
		pick = '0;
		for (int i = CORES_COUNT - 1; i >= 0; i--) begin
			if (pending[i] && (!instr_any || core_instr[i]))
				pick = IDX_W'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_q <= '0;
			pending <= '0;
			core_ready <= '0;
			claimed <= 1'b0;
			sel <= '0;
			mem_valid <= 1'b0;
			mem_wstrb <= '0;
		end else begin
			valid_q <= core_valid;
			core_ready <= '0;
			for (int i = 0; i < CORES_COUNT; i++) begin
				if (core_valid[i] && !valid_q[i])
					pending[i] <= 1'b1;
				else if (!core_valid[i] || (served && sel == IDX_W'(i)))
					pending[i] <= 1'b0;
			end

			if (claimed) begin
				if (served) begin
					claimed <= 1'b0;
					mem_valid <= 1'b0;
					mem_wstrb <= '0;
					core_ready[sel] <= 1'b1;
				end else if (!mem_valid) begin
					mem_valid <= 1'b1;
					mem_wstrb <= core_wstrb[sel];
				end
			end else if (|pending) begin
				claimed <= 1'b1;
				sel <= pick;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (claimed && !mem_valid) begin
			mem_instr <= core_instr[sel];
			mem_addr <= core_addr[sel];
			mem_wdata <= core_wdata[sel];
		end
		if (served)
			core_rdata[sel] <= mem_rdata;
	end

endmodule

`default_nettype wire

/* hdl/mem_mover.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_mover #(
	parameter cluster_mem_pkg::word_t PRIVATE_MEM_LEN = 32'h0000_0100
) (
	input  wire                            clk,
	input  wire                            resetn,

	input  wire                            start,
	input  wire  cluster_mem_pkg::word_t   src,
	input  wire  cluster_mem_pkg::word_t   dst,
	output logic                           busy,
	output logic                           done,

	output logic                           copy_mem_valid,
	output cluster_mem_pkg::word_t         copy_mem_addr,
	output cluster_mem_pkg::word_t         copy_mem_wdata,
	output cluster_mem_pkg::strb_t         copy_mem_wstrb,
	input  wire                            copy_mem_ready,
	input  wire  cluster_mem_pkg::word_t   copy_mem_rdata
);
	import cluster_mem_pkg::*;

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_READ  = 2'd1;
	localparam logic [1:0] ST_WRITE = 2'd2;

	logic [1:0] state;
	word_t      rd_addr;
	word_t      wr_addr;
	word_t      remaining;
	word_t      data_q;
	logic       ack;

	assign busy = (state != ST_IDLE);
	assign ack = copy_mem_valid && copy_mem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			remaining <= '0;
			done <= 1'b0;
			copy_mem_valid <= 1'b0;
			copy_mem_wstrb <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						remaining <= PRIVATE_MEM_LEN;
						state <= ST_READ;
					end
				end
				ST_READ: begin
					if (ack) begin
						copy_mem_valid <= 1'b0;
						state <= ST_WRITE;
					end else if (remaining == '0) begin
						done <= 1'b1;
						state <= ST_IDLE;
					end else if (!copy_mem_valid) begin
						copy_mem_valid <= 1'b1;
						copy_mem_wstrb <= '0;
					end
				end
				ST_WRITE: begin
					if (ack) begin
						copy_mem_valid <= 1'b0;
						copy_mem_wstrb <= '0;
						remaining <= remaining - WORD_BYTES;
						state <= ST_READ;
					end else if (!copy_mem_valid) begin
						copy_mem_valid <= 1'b1;
						copy_mem_wstrb <= STRB_FULL;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Copy addresses and the word in transit
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			rd_addr <= src;
			wr_addr <= dst;
		end
		if (state == ST_READ && ack) begin
			data_q <= copy_mem_rdata;
			rd_addr <= rd_addr + WORD_BYTES;
		end
		if (state == ST_WRITE && ack)
			wr_addr <= wr_addr + WORD_BYTES;
		if (!copy_mem_valid && state == ST_READ)
			copy_mem_addr <= rd_addr;
		if (!copy_mem_valid && state == ST_WRITE) begin
			copy_mem_addr <= wr_addr;
			copy_mem_wdata <= data_q;
		end
	end

endmodule

`default_nettype wire
